/* branch_predictor.sv */
`default_nettype none
`include "rv32i_ex_config.svh"

module branch_predictor (
	input  wire  clk,
	input  wire  arst_n,
	input  wire  pred_req,      // Conditional branch in decode
	input  wire  resolve,       // Branch resolved in execute
	input  wire  resolve_taken,
	output logic pred_taken
);
	logic [1:0] ctr; // 0,1 not taken, 2,3 taken

	// Saturating update at the edge that registers the branch outputs
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ctr <= `PRED_RESET;
		end else if (resolve) begin
			if (resolve_taken) begin
				if (ctr != 2'b11) begin
					ctr <= ctr + 2'd1;
				end
			end else begin
				if (ctr != 2'b00) begin
					ctr <= ctr - 2'd1;
				end
			end
		end
	end

	assign pred_taken = ctr[1] & pred_req; // Only answers a real request

endmodule

`default_nettype wire

/* decode_stage.sv */
`default_nettype none
`include "rv32i_ex_config.svh"

module decode_stage (
	input  wire                            clk,
	input  wire                            arst_n,
	input  wire                            issue,
	input  wire rv32i_ex_pkg::instr_word_t instr,
	input  wire [`XLEN-1:0]                pc,
	input  wire [`XLEN-1:0]                rs1_val,
	input  wire [`XLEN-1:0]                rs2_val,
	output logic                           pred_req,
	input  wire                            pred_taken,
	ex_bus_if.stage_out                    bus
);
	logic [6:0]       opcode;
	logic [2:0]       funct3;
	logic             alt;        // funct7 bit 5, SUB and SRA select
	logic [`XLEN-1:0] imm_i;
	logic [`XLEN-1:0] imm_s;
	logic [`XLEN-1:0] imm_b;
	logic [`XLEN-1:0] imm_u;
	logic [`XLEN-1:0] imm_j;
	logic [3:0]       alu_op_d;
	logic [2:0]       br_cond_d;
	logic             is_branch_d;
	logic             is_jump_d;
	logic             is_jalr_d;
	logic             illegal_d;
	logic [`XLEN-1:0] op_a_d;
	logic [`XLEN-1:0] op_b_d;
	logic [`XLEN-1:0] imm_d;

	// Shared by OP and OP-IMM, SUB only exists in the register form
	function automatic logic [3:0] alu_decode(input logic [2:0] f3, input logic f7_5,
		input logic reg_op);
		case (f3)
			`F3_ADD:  return (reg_op && f7_5) ? `ALU_SUB : `ALU_ADD;
			`F3_SLL:  return `ALU_SLL;
			`F3_SLT:  return `ALU_SLT;
			`F3_SLTU: return `ALU_SLTU;
			`F3_XOR:  return `ALU_XOR;
			`F3_SR:   return f7_5 ? `ALU_SRA : `ALU_SRL;
			`F3_OR:   return `ALU_OR;
			default:  return `ALU_AND;
		endcase
	endfunction

	assign opcode = instr.r.opcode;
	assign funct3 = instr.r.funct3;
	assign alt    = instr.r.funct7[5];

	assign imm_i = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
	assign imm_s = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
	assign imm_b = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
		instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
	assign imm_u = {instr.u.imm_31_12, 12'b0};
	assign imm_j = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
		instr.j.imm_11, instr.j.imm_10_1, 1'b0};

	always_comb begin
		alu_op_d    = `ALU_ADD;   // Address and link adds by default
		br_cond_d   = `BR_NONE;
		is_branch_d = 1'b0;
		is_jump_d   = 1'b0;
		is_jalr_d   = 1'b0;
		illegal_d   = 1'b0;
		op_a_d      = rs1_val;
		op_b_d      = imm_i;
		imm_d       = imm_i;
		case (opcode)
			`OPC_LUI: begin
				alu_op_d = `ALU_PASS_B;
				op_b_d   = imm_u;
				imm_d    = imm_u;
			end
			`OPC_AUIPC: begin
				op_a_d = pc;
				op_b_d = imm_u;
				imm_d  = imm_u;
			end
			`OPC_JAL: begin
				is_jump_d = 1'b1;
				op_a_d    = pc;               // Link value pc+4
				op_b_d    = `XLEN'(4);
				imm_d     = imm_j;
			end
			`OPC_JALR: begin
				is_jump_d = 1'b1;
				is_jalr_d = 1'b1;
				op_a_d    = pc;
				op_b_d    = `XLEN'(4);
				illegal_d = (funct3 != `F3_JALR);
			end
			`OPC_BRANCH: begin
				is_branch_d = 1'b1;
				alu_op_d    = `ALU_SUB;
				op_b_d      = rs2_val;
				imm_d       = imm_b;
				case (funct3)
					`F3_BEQ:  br_cond_d = `BR_EQ;
					`F3_BNE:  br_cond_d = `BR_NE;
					`F3_BLT:  br_cond_d = `BR_LT;
					`F3_BGE:  br_cond_d = `BR_GE;
					`F3_BLTU: br_cond_d = `BR_LTU;
					`F3_BGEU: br_cond_d = `BR_GEU;
					default:  illegal_d = 1'b1; // 010 and 011 unused
				endcase
			end
			`OPC_LOAD:                          // LB LH LW LBU LHU
				illegal_d = (funct3[1:0] == 2'b11) || (funct3 == 3'b110);
			`OPC_STORE: begin                   // SB SH SW
				op_b_d    = imm_s;
				imm_d     = imm_s;
				illegal_d = funct3[2] || (funct3[1:0] == 2'b11);
			end
			`OPC_IMMOP:
				alu_op_d = alu_decode(funct3, alt, 1'b0);
			`OPC_ALUOP: begin
				alu_op_d = alu_decode(funct3, alt, 1'b1);
				op_b_d   = rs2_val;
			end
			default:
				illegal_d = 1'b1;
		endcase
	end

	assign pred_req = issue && is_branch_d && !illegal_d; // Legal conditional branches only

	// ID/EX register
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			bus.valid <= 1'b0;
		end else begin
			bus.valid <= issue;
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			bus.alu_op    <= alu_op_d;
			bus.br_cond   <= br_cond_d;
			bus.is_branch <= is_branch_d;
			bus.is_jump   <= is_jump_d;
			bus.is_jalr   <= is_jalr_d;
			bus.illegal   <= illegal_d;
			bus.op_a      <= op_a_d;
			bus.op_b      <= op_b_d;
			bus.rs1       <= rs1_val;
			bus.imm       <= imm_d;
			bus.pc        <= pc;
			bus.predicted <= pred_taken; // Counter state before this cycle's update
		end
	end

endmodule

`default_nettype wire

/* ex_bus_if.sv */
`default_nettype none
`include "rv32i_ex_config.svh"

interface ex_bus_if;
	logic             valid;      // One cycle per issued instruction
	logic [3:0]       alu_op;
	logic [2:0]       br_cond;
	logic             is_branch;  // Conditional branch
	logic             is_jump;    // JAL or JALR
	logic             is_jalr;
	logic             illegal;
	logic [`XLEN-1:0] op_a;
	logic [`XLEN-1:0] op_b;
	logic [`XLEN-1:0] rs1;        // Raw rs1 value for the JALR target
	logic [`XLEN-1:0] imm;
	logic [`XLEN-1:0] pc;
	logic             predicted;  // Predictor answer at issue time

	modport stage_out (
		output valid, alu_op, br_cond, is_branch, is_jump, is_jalr, illegal,
		output op_a, op_b, rs1, imm, pc, predicted
	);

	modport stage_in (
		input valid, alu_op, br_cond, is_branch, is_jump, is_jalr, illegal,
		input op_a, op_b, rs1, imm, pc, predicted
	);
endinterface

`default_nettype wire

/* ex_scoreboard.sv */
`default_nettype none
`include "rv32i_ex_config.svh"

module ex_scoreboard (
	input  wire                            clk,
	input  wire                            arst_n,
	input  wire                            issue,
	input  wire rv32i_ex_pkg::instr_word_t instr,
	input  wire [`XLEN-1:0]                pc,
	input  wire [`XLEN-1:0]                rs1_val,
	input  wire [`XLEN-1:0]                rs2_val,
	input  wire                            out_valid,
	input  wire [`XLEN-1:0]                result,
	input  wire                            taken,
	input  wire [`XLEN-1:0]                target,
	input  wire                            mispredict,
	input  wire                            illegal,
	output int                             mismatches,
	output int                             protocol_errors,
	output int                             pending
);
	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed {
		logic [31:0] instr;
		logic [31:0] result;
		logic [31:0] target;
		logic        taken;
		logic        check_target; // Jumps and legal branches
		logic        mispredict;
		logic        illegal;
		logic        resolves;     // Legal conditional branch
	} expect_t;

	expect_t    exp_q[$];            // Oldest instruction first
	expect_t    nxt;
	expect_t    head;
	logic [1:0] ctr = `PRED_RESET;   // Reference predictor counter
	logic       upd_valid = 1'b0;    // Branch waiting to update ctr
	logic       upd_dir = 1'b0;

	// RV32I register and immediate arithmetic
	function automatic logic [31:0] alu(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'b000:  return alt ? a - b : a + b;
			3'b001:  return a << b[4:0];
			3'b010:  return {31'b0, $signed(a) < $signed(b)};
			3'b011:  return {31'b0, a < b};   // Unsigned compare
			3'b100:  return a ^ b;
			3'b101: begin
				if (alt) begin
					return $signed(a) >>> b[4:0];
				end
				return a >> b[4:0];
			end
			3'b110:  return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic expect_t model(input logic [31:0] w, input logic [31:0] pc_v,
		input logic [31:0] a, input logic [31:0] b, input logic [1:0] counter);
		expect_t     e;
		logic [2:0]  f3;
		logic [31:0] imm_i;
		logic [31:0] imm_s;
		logic [31:0] imm_b;
		logic [31:0] imm_u;
		logic [31:0] imm_j;
		logic        cond;
		e       = '0;
		e.instr = w;
		f3      = w[14:12];
		cond    = 1'b0;
		imm_i   = {{20{w[31]}}, w[31:20]};
		imm_s   = {{20{w[31]}}, w[31:25], w[11:7]};
		imm_b   = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
		imm_u   = {w[31:12], 12'b0};
		imm_j   = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
		case (w[6:0])
			`OPC_LUI:   e.result = imm_u;
			`OPC_AUIPC: e.result = pc_v + imm_u;
			`OPC_JAL: begin
				e.result       = pc_v + 32'd4;   // Link address
				e.taken        = 1'b1;
				e.target       = pc_v + imm_j;
				e.check_target = 1'b1;
			end
			`OPC_JALR: begin
				e.illegal      = (f3 != 3'b000);
				e.result       = pc_v + 32'd4;
				e.taken        = 1'b1;
				e.target       = (a + imm_i) & ~32'd1;
				e.check_target = 1'b1;
			end
			`OPC_BRANCH: begin
				case (f3)
					3'b000:  cond = (a == b);
					3'b001:  cond = (a != b);
					3'b100:  cond = $signed(a) < $signed(b);
					3'b101:  cond = $signed(a) >= $signed(b);
					3'b110:  cond = a < b;
					3'b111:  cond = a >= b;
					default: e.illegal = 1'b1;
				endcase
				e.result       = a - b;           // ALU subtracts for the compare
				e.taken        = cond;
				e.target       = pc_v + imm_b;
				e.check_target = 1'b1;
				e.mispredict   = (counter[1] != cond); // Counter bit 1 is the guess
				e.resolves     = 1'b1;
			end
			`OPC_LOAD: begin
				e.illegal = (f3 == 3'b011) || (f3 > 3'b101);
				e.result  = a + imm_i;           // Effective address
			end
			`OPC_STORE: begin
				e.illegal = (f3 > 3'b010);
				e.result  = a + imm_s;
			end
			`OPC_IMMOP: e.result = alu(f3, w[30] && (f3 == 3'b101), a, imm_i);
			`OPC_ALUOP: e.result = alu(f3, w[30], a, b);
			default:    e.illegal = 1'b1;
		endcase
		if (e.illegal) begin
			e.result       = '0;
			e.taken        = 1'b0;
			e.mispredict   = 1'b0;
			e.check_target = 1'b0;
			e.resolves     = 1'b0;                // Counter untouched
		end
		return e;
	endfunction

	task automatic compare_field(input string name, input logic [31:0] actual,
		input logic [31:0] expected, input logic [31:0] word);
		if (actual !== expected) begin
			mismatches++;
			$display("Fail %s: got 0x%h, expected 0x%h, instr 0x%h at %0t ns",
				name, actual, expected, word, $time);
		end
	endtask

	initial begin
		mismatches      = 0;
		protocol_errors = 0;
		pending         = 0;
	end

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ctr       = `PRED_RESET;
			upd_valid = 1'b0;
			upd_dir   = 1'b0;
			exp_q.delete();
		end else begin
			if (out_valid) begin
				if (exp_q.size() == 0) begin
					protocol_errors++;
					$display("Output valid at %0t ns with no instruction outstanding", $time);
				end else begin
					head = exp_q.pop_front();
					compare_field("illegal", illegal, head.illegal, head.instr);
					compare_field("result", result, head.result, head.instr);
					compare_field("taken", taken, head.taken, head.instr);
					compare_field("mispredict", mispredict, head.mispredict, head.instr);
					if (head.check_target) begin
						compare_field("target", target, head.target, head.instr);
					end
				end
			end
			if (issue) begin
				nxt = model(instr, pc, rs1_val, rs2_val, ctr); // Guess from pre-update counter
				exp_q.push_back(nxt);
			end
			// Branch issued one edge earlier resolves at this edge
			if (upd_valid) begin
				if (upd_dir && ctr != 2'b11) begin
					ctr = ctr + 2'd1;
				end else if (!upd_dir && ctr != 2'b00) begin
					ctr = ctr - 2'd1;
				end
			end
			upd_valid = issue && nxt.resolves;
			upd_dir   = nxt.taken;
			pending   = exp_q.size();
		end
	end

endmodule

`default_nettype wire

/* execute_stage.sv */
`default_nettype none
`include "rv32i_ex_config.svh"

module execute_stage (
	input  wire              clk,
	input  wire              arst_n,
	ex_bus_if.stage_in       bus,
	output logic             resolve,
	output logic             resolve_taken,
	output logic             out_valid,
	output logic [`XLEN-1:0] result,
	output logic             taken,
	output logic [`XLEN-1:0] target,
	output logic             mispredict,
	output logic             illegal
);
	logic [4:0]       shamt;
	logic [`XLEN-1:0] alu_res;
	logic             cond;        // Branch condition holds
	logic             taken_d;
	logic             mispredict_d;
	logic [`XLEN-1:0] pc_target;
	logic [`XLEN-1:0] jalr_sum;
	logic [`XLEN-1:0] target_d;

	assign shamt = bus.op_b[4:0];

	// ALU
	always_comb begin
		case (bus.alu_op)
			`ALU_AND:    alu_res = bus.op_a & bus.op_b;
			`ALU_OR:     alu_res = bus.op_a | bus.op_b;
			`ALU_ADD:    alu_res = bus.op_a + bus.op_b;
			`ALU_SUB:    alu_res = bus.op_a - bus.op_b;
			`ALU_SLT:    alu_res = `XLEN'($signed(bus.op_a) < $signed(bus.op_b));
			`ALU_SLTU:   alu_res = `XLEN'(bus.op_a < bus.op_b);
			`ALU_SRL:    alu_res = bus.op_a >> shamt;
			`ALU_SRA:    alu_res = $signed(bus.op_a) >>> shamt; // Sign fills from the top
			`ALU_SLL:    alu_res = bus.op_a << shamt;
			`ALU_XOR:    alu_res = bus.op_a ^ bus.op_b;
			`ALU_PASS_B: alu_res = bus.op_b;
			default:     alu_res = '0;
		endcase
	end

	// Branch comparator
	always_comb begin
		case (bus.br_cond)
			`BR_EQ:  cond = (bus.op_a == bus.op_b);
			`BR_NE:  cond = (bus.op_a != bus.op_b);
			`BR_LT:  cond = ($signed(bus.op_a) < $signed(bus.op_b));
			`BR_GE:  cond = ($signed(bus.op_a) >= $signed(bus.op_b));
			`BR_LTU: cond = (bus.op_a < bus.op_b);
			`BR_GEU: cond = (bus.op_a >= bus.op_b);
			default: cond = 1'b0;
		endcase
	end

	assign pc_target = bus.pc + bus.imm;                 // Branch and JAL
	assign jalr_sum  = bus.rs1 + bus.imm;
	assign target_d  = bus.is_jalr ? {jalr_sum[`XLEN-1:1], 1'b0} : pc_target;

	assign taken_d      = !bus.illegal && (bus.is_jump || (bus.is_branch && cond));
	assign mispredict_d = !bus.illegal && bus.is_branch && (bus.predicted != cond);

	// Predictor update, illegal encodings leave the counter alone
	assign resolve       = bus.valid && bus.is_branch && !bus.illegal;
	assign resolve_taken = cond;

	// Output register
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid  <= 1'b0;
			taken      <= 1'b0;
			mispredict <= 1'b0;
			illegal    <= 1'b0;
		end else begin
			out_valid <= bus.valid;
			if (bus.valid) begin                            // Hold until next result
				taken      <= taken_d;
				mispredict <= mispredict_d;
				illegal    <= bus.illegal;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (bus.valid) begin
			result <= bus.illegal ? '0 : alu_res;
			target <= target_d;
		end
	end

endmodule

`default_nettype wire

/* rv32i_ex_config.svh */
`ifndef RV32I_EX_CONFIG_SVH
`define RV32I_EX_CONFIG_SVH

`define XLEN            32

`define OPC_LUI         7'b0110111
`define OPC_AUIPC       7'b0010111
`define OPC_JAL         7'b1101111
`define OPC_JALR        7'b1100111
`define OPC_BRANCH      7'b1100011
`define OPC_LOAD        7'b0000011
`define OPC_STORE       7'b0100011
`define OPC_IMMOP       7'b0010011
`define OPC_ALUOP       7'b0110011

`define F3_ADD          3'b000 // ADD, SUB and ADDI
`define F3_SLL          3'b001
`define F3_SLT          3'b010
`define F3_SLTU         3'b011
`define F3_XOR          3'b100
`define F3_SR           3'b101 // SRL or SRA, picked by funct7 bit 5
`define F3_OR           3'b110
`define F3_AND          3'b111
`define F3_JALR         3'b000

`define F3_BEQ          3'b000
`define F3_BNE          3'b001
`define F3_BLT          3'b100
`define F3_BGE          3'b101
`define F3_BLTU         3'b110
`define F3_BGEU         3'b111

`define ALU_AND         4'b0000
`define ALU_OR          4'b0001
`define ALU_ADD         4'b0010
`define ALU_SRL         4'b0011
`define ALU_SRA         4'b0100
`define ALU_SLL         4'b0101
`define ALU_SUB         4'b0110
`define ALU_SLT         4'b0111
`define ALU_XOR         4'b1000
`define ALU_SLTU        4'b1001
`define ALU_PASS_B      4'b1010 // LUI only

`define BR_NONE         3'b000
`define BR_EQ           3'b001
`define BR_NE           3'b010
`define BR_LT           3'b011
`define BR_GE           3'b100
`define BR_LTU          3'b101
`define BR_GEU          3'b110

`define PRED_RESET      2'b01 // Weakly not taken

`endif

/* rv32i_ex_pkg.sv */
`default_nettype none

package rv32i_ex_pkg;

	typedef struct packed {
		logic [6:0]  funct7;
		logic [4:0]  rs2;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm_11_0;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0]  imm_11_5;
		logic [4:0]  rs2;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  imm_4_0;
		logic [6:0]  opcode;
	} s_fmt_t;

	typedef struct packed {
		logic        imm_12;
		logic [5:0]  imm_10_5;
		logic [4:0]  rs2;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [3:0]  imm_4_1;
		logic        imm_11; // Sits in the rd slot of bit 7
		logic [6:0]  opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm_31_12;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef struct packed {
		logic        imm_20;
		logic [9:0]  imm_10_1;
		logic        imm_11;
		logic [7:0]  imm_19_12;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} j_fmt_t;

	// One instruction word, six views of its fields
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} instr_word_t;

endpackage

`default_nettype wire

/* rv32i_execute.f */
+incdir+.
rv32i_ex_pkg.sv
ex_bus_if.sv
decode_stage.sv
branch_predictor.sv
execute_stage.sv
rv32i_execute.sv
rv32i_execute_properties.sv
ex_scoreboard.sv
tb_rv32i_execute.sv

/* rv32i_execute.sv */
`default_nettype none
`include "rv32i_ex_config.svh"

module rv32i_execute (
	input  wire              clk,
	input  wire              arst_n,
	input  wire              issue,
	input  wire [31:0]       instr,
	input  wire [`XLEN-1:0]  pc,
	input  wire [`XLEN-1:0]  rs1_val,
	input  wire [`XLEN-1:0]  rs2_val,
	output logic             out_valid,
	output logic [`XLEN-1:0] result,
	output logic             taken,
	output logic [`XLEN-1:0] target,
	output logic             mispredict,
	output logic             illegal
);
	logic pred_req;      // Decode asks for a prediction
	logic pred_taken;
	logic resolve;       // Execute reports a resolved branch
	logic resolve_taken;

	ex_bus_if bus_if ();  // ID/EX contents

	decode_stage u_decode (
		.clk        (clk),
		.arst_n     (arst_n),
		.issue      (issue),
		.instr      (instr),
		.pc         (pc),
		.rs1_val    (rs1_val),
		.rs2_val    (rs2_val),
		.pred_req   (pred_req),
		.pred_taken (pred_taken),
		.bus        (bus_if.stage_out)
	);

	branch_predictor u_predictor (
		.clk           (clk),
		.arst_n        (arst_n),
		.pred_req      (pred_req),
		.resolve       (resolve),
		.resolve_taken (resolve_taken),
		.pred_taken    (pred_taken)
	);

	execute_stage u_execute (
		.clk           (clk),
		.arst_n        (arst_n),
		.bus           (bus_if.stage_in),
		.resolve       (resolve),
		.resolve_taken (resolve_taken),
		.out_valid     (out_valid),
		.result        (result),
		.taken         (taken),
		.target        (target),
		.mispredict    (mispredict),
		.illegal       (illegal)
	);

endmodule

`default_nettype wire

/* rv32i_execute_properties.sv */
`default_nettype none

module rv32i_execute_properties (
	input wire clk,
	input wire arst_n,
	input wire issue,
	input wire out_valid,
	input wire taken,
	input wire mispredict,
	input wire illegal
);
	timeunit 1ns;
	timeprecision 100ps;

	int assert_fails = 0; // Read by the testbench top

	a_issue_to_valid: assert property (@(posedge clk) disable iff (!arst_n)
		issue |-> ##2 out_valid)
		else begin
			$error("out_valid missing two cycles after issue");
			assert_fails++;
		end

	a_no_spurious_valid: assert property (@(posedge clk) disable iff (!arst_n)
		!issue |-> ##2 !out_valid)
		else begin
			$error("out_valid without an issue two cycles earlier");
			assert_fails++;
		end

	// Control outputs stay low while reset is held
	a_reset_quiet: assert property (@(posedge clk)
		!arst_n |-> !out_valid && !taken && !mispredict && !illegal)
		else begin
			$error("Control output high during reset");
			assert_fails++;
		end

	// Held between results, so it may only move with out_valid
	a_mispredict_with_valid: assert property (@(posedge clk) disable iff (!arst_n)
		$changed(mispredict) |-> out_valid)
		else begin
			$error("mispredict changed without out_valid");
			assert_fails++;
		end

endmodule

`default_nettype wire

/* tb_rv32i_execute.sv */
`default_nettype none
`include "rv32i_ex_config.svh"

module tb_rv32i_execute;
	timeunit 1ns;
	timeprecision 100ps;
	import rv32i_ex_pkg::*;

	localparam int NUM_INSTR   = 600;
	localparam int CLK_PERIOD  = 10;
	localparam int WATCHDOG_NS = (NUM_INSTR * 2 + 50) * CLK_PERIOD; // Worst case two cycles each

	logic             clk;
	logic             arst_n;
	logic             issue;
	instr_word_t      instr;
	logic [`XLEN-1:0] pc;
	logic [`XLEN-1:0] rs1_val;
	logic [`XLEN-1:0] rs2_val;
	logic             out_valid;
	logic [`XLEN-1:0] result;
	logic             taken;
	logic [`XLEN-1:0] target;
	logic             mispredict;
	logic             illegal;
	int               mismatches;
	int               protocol_errors;
	int               pending;
	logic [15:0]      lfsr;   // Stimulus generator state

	always #(CLK_PERIOD / 2) clk = ~clk;

	rv32i_execute UUT (
		.clk        (clk),
		.arst_n     (arst_n),
		.issue      (issue),
		.instr      (instr),
		.pc         (pc),
		.rs1_val    (rs1_val),
		.rs2_val    (rs2_val),
		.out_valid  (out_valid),
		.result     (result),
		.taken      (taken),
		.target     (target),
		.mispredict (mispredict),
		.illegal    (illegal)
	);

	ex_scoreboard u_checker (
		.clk             (clk),
		.arst_n          (arst_n),
		.issue           (issue),
		.instr           (instr),
		.pc              (pc),
		.rs1_val         (rs1_val),
		.rs2_val         (rs2_val),
		.out_valid       (out_valid),
		.result          (result),
		.taken           (taken),
		.target          (target),
		.mispredict      (mispredict),
		.illegal         (illegal),
		.mismatches      (mismatches),
		.protocol_errors (protocol_errors),
		.pending         (pending)
	);

	bind rv32i_execute rv32i_execute_properties u_props (
		.clk        (clk),
		.arst_n     (arst_n),
		.issue      (issue),
		.out_valid  (out_valid),
		.taken      (taken),
		.mispredict (mispredict),
		.illegal    (illegal)
	);

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic next_bit();
		logic fb;
		fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			v = {v[30:0], next_bit()};
		end
		return v;
	endfunction

	// Small set so every branch condition sees both outcomes
	function automatic logic [`XLEN-1:0] branch_operand();
		case (rand_bits(2))
			2'd0:    return 32'h0000_0000;
			2'd1:    return 32'h0000_0001;
			2'd2:    return 32'hffff_ffff;
			default: return 32'h8000_0000;
		endcase
	endfunction

	task automatic make_instr(output instr_word_t w);
		logic [3:0] kind;
		w    = rand_bits(32);                      // Random fields, then fix the encoding
		kind = 4'(rand_bits(4));
		if (kind == 4'd0) begin                    // Roughly one in sixteen illegal
			case (rand_bits(2))
				2'd0: w.r.opcode = 7'b1110011;         // SYSTEM, outside the slice
				2'd1: begin
					w.b.opcode = `OPC_BRANCH;
					w.b.funct3 = {2'b01, next_bit()};
				end
				2'd2: begin
					w.i.opcode = `OPC_LOAD;
					w.i.funct3 = {next_bit(), 2'b11};
				end
				default: begin
					w.i.opcode = `OPC_JALR;
					w.i.funct3 = 3'b001 | 3'(rand_bits(3));
				end
			endcase
		end else begin
			case (kind)
				4'd1: w.u.opcode = `OPC_LUI;
				4'd2: w.u.opcode = `OPC_AUIPC;
				4'd3: w.j.opcode = `OPC_JAL;
				4'd4: begin
					w.i.opcode = `OPC_JALR;
					w.i.funct3 = `F3_JALR;
				end
				4'd5, 4'd6, 4'd7: begin
					w.b.opcode = `OPC_BRANCH;
					if (w.b.funct3[2:1] == 2'b01) begin  // Move off the unused codes
						w.b.funct3[2] = 1'b1;
					end
				end
				4'd8: begin
					w.i.opcode = `OPC_LOAD;
					if (w.i.funct3 == 3'b011 || w.i.funct3[2:1] == 2'b11) begin
						w.i.funct3 = 3'b010;
					end
				end
				4'd9: begin
					w.s.opcode    = `OPC_STORE;
					w.s.funct3[2] = 1'b0;
					if (w.s.funct3 == 3'b011) begin
						w.s.funct3 = 3'b010;
					end
				end
				4'd10, 4'd11, 4'd12: begin
					w.i.opcode = `OPC_IMMOP;
					if (w.i.funct3 == `F3_SLL) begin
						w.i.imm_11_0[11:5] = 7'b0;
					end else if (w.i.funct3 == `F3_SR) begin
						w.i.imm_11_0[11:5] = {1'b0, next_bit(), 5'b0}; // SRLI or SRAI
					end
				end
				default: begin
					w.r.opcode = `OPC_ALUOP;
					w.r.funct7 = {1'b0, next_bit(), 5'b0};
				end
			endcase
		end
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns before the tests completed", WATCHDOG_NS);
		$display("Test failed");
		$finish;
	end

	initial begin
		instr_word_t w;
		clk     = 1'b0;
		arst_n  = 1'b1;
		issue   = 1'b0;
		instr   = '0;
		pc      = '0;
		rs1_val = '0;
		rs2_val = '0;
		lfsr    = 16'd46106;
		#1 arst_n = 1'b0;                          // Clean falling edge for the flops
		repeat (4) @(posedge clk);
		#1 arst_n = 1'b1;
		for (int n = 0; n < NUM_INSTR; n++) begin
			make_instr(w);
			instr = w;
			pc    = rand_bits(30) << 2;              // Word aligned
			if (w.r.opcode == `OPC_BRANCH) begin
				rs1_val = branch_operand();
				rs2_val = branch_operand();
			end else begin
				rs1_val = rand_bits(32);
				rs2_val = rand_bits(32);
			end
			issue = 1'b1;
			@(posedge clk);
			#1 issue = 1'b0;
			if (next_bit()) begin                   // Optional idle cycle
				@(posedge clk);
				#1;
			end
		end
		repeat (4) @(posedge clk);                 // Last result is out two edges after issue
		if (pending != 0) begin
			$display("%0d expected results never came out of the DUT", pending);
		end
		$display("Errors: %0d mismatches, %0d protocol, %0d unfinished, %0d assertion failures",
			mismatches, protocol_errors, pending, UUT.u_props.assert_fails);
		if (mismatches + protocol_errors + pending + UUT.u_props.assert_fails == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
